/* sim/br_tests.txt */
# pc cmt is_branch cond sel1 sel2 imm rs1 rs2 pred_taken pred_pc byp0 byp1 (hex)
# then expected: taken target dir_fail addr_fail
00001000 1 1 6 0 0 00000010 00000005 00000005 1 00001040 00000000 00000000 1 00001040 0 0
00001010 0 1 6 0 0 00000010 00000005 00000006 0 00001018 00000000 00000000 0 00001018 0 0
00001020 1 1 7 0 0 00000008 00000001 00000002 1 00001040 00000000 00000000 1 00001040 0 0
00001030 1 1 7 0 0 00000008 00000007 00000007 0 00001034 00000000 00000000 0 00001034 0 0
00001040 0 1 8 0 0 00000004 80000000 00000001 1 00001050 00000000 00000000 1 00001050 0 0
00001050 1 1 8 0 0 00000004 7fffffff 80000000 0 00001054 00000000 00000000 0 00001054 0 0
00001060 0 1 9 0 0 fffffffc 7fffffff 80000000 1 00001050 00000000 00000000 1 00001050 0 0
00001070 0 1 9 0 0 00000004 ffffffff 00000000 0 00001078 00000000 00000000 0 00001078 0 0
00001080 1 1 a 0 0 00000020 00000001 80000000 1 00001100 00000000 00000000 1 00001100 0 0
00001090 0 1 a 0 0 00000020 ffffffff 00000000 0 00001098 00000000 00000000 0 00001098 0 0
000010a0 1 1 b 0 0 00000002 80000000 7fffffff 1 000010a8 00000000 00000000 1 000010a8 0 0
000010b0 1 1 b 0 0 00000002 00000000 00000001 0 000010b4 00000000 00000000 0 000010b4 0 0
000010c0 1 1 4 0 0 00000100 00000000 00000000 1 000014c0 00000000 00000000 1 000014c0 0 0
000010d0 0 1 5 0 0 ffffff00 00000000 00000000 1 00000cd0 00000000 00000000 1 00000cd0 0 0
000010e0 1 1 3 0 0 00000001 00002000 00000000 1 00002004 00000000 00000000 1 00002004 0 0
000010f0 1 1 3 1 0 00000000 dead0000 00000000 1 00003000 00003000 11111111 1 00003000 0 0
00001100 0 1 6 1 2 00000004 00000001 00000002 1 00001110 0000abcd 0000abcd 1 00001110 0 0
00001110 0 1 3 2 0 00000003 00000000 00000000 1 0000400c 00000005 00004000 1 0000400c 0 0
00001120 1 1 7 0 0 00000008 00000003 00000003 1 00001140 00000000 00000000 0 00001124 1 1
00001130 1 0 0 0 0 00000000 00000000 00000000 0 00001134 00000000 00000000 0 00001134 0 0
00001140 1 1 6 0 0 00000004 00000009 00000009 1 00001150 00000000 00000000 1 00001150 0 0
00001150 0 0 0 0 0 00000000 00000000 00000000 0 00001158 00000000 00000000 0 00001158 0 0
00001160 1 1 4 0 0 00000040 00000000 00000000 1 00001200 00000000 00000000 1 00001260 0 1
00001170 0 1 a 0 0 00000004 00000001 00000002 1 00001180 00000000 00000000 1 00001180 0 0
00001180 1 0 0 0 0 00000000 00000000 00000000 0 00001184 00000000 00000000 0 00001184 0 0
00001190 1 1 3 1 0 00000002 00000000 00000000 1 00005008 00005000 00000000 1 00005008 0 0
000011a0 0 1 8 0 0 00000008 ffffffff 00000001 0 000011a8 00000000 00000000 1 000011c0 1 1
000011b0 1 1 9 0 0 00000004 00000000 00000000 1 000011c0 00000000 00000000 1 000011c0 0 0
000011c0 0 1 7 0 0 00000004 00000001 00000001 0 000011c8 00000000 00000000 0 000011c8 0 0
000011d0 0 1 b 0 0 00000004 ffffffff fffffffe 1 000011e0 00000000 00000000 1 000011e0 0 0
000011e0 0 0 6 0 0 00000004 00000000 00000000 0 000011e8 00000000 00000000 0 000011e8 0 0
000011f0 1 1 6 0 1 00000004 00000010 00000010 0 000011f4 00000011 00000000 0 000011f4 0 0
00001200 1 1 3 0 0 00000000 00006000 00000000 1 00006004 00000000 00000000 1 00006000 0 1

/* tb.f */
+incdir+hw
hw/br_uop_pkg.sv
hw/br_pipe_pkg.sv
hw/br_stage_reg.sv
hw/br_operand_sel.sv
hw/br_resolve.sv
hw/br_redirect.sv
hw/br_exec_top.sv
sim/br_exec_asserts.sv
sim/br_exec_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = br_exec_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/br_exec_tb.sv */
`timescale 1ns/1ps

`include "br_defines.svh"

module br_exec_tb;

    typedef struct packed {
        br_pipe_pkg::br_result_t r;
        int                      res_edge;
    } expect_t;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    br_pipe_pkg::br_issue_t  in_pkt;
    logic [`BR_XLEN-1:0]     byp0;
    logic [`BR_XLEN-1:0]     byp1;
    logic                    res_valid;
    br_pipe_pkg::br_result_t res;
    logic                    redirect;
    logic [`BR_XLEN-1:0]     redirect_pc;
    logic                    upd_valid;
    br_pipe_pkg::br_update_t upd;

    br_pipe_pkg::br_issue_t  vec_pkt[$];
    logic [`BR_XLEN-1:0]     vec_byp0[$];
    logic [`BR_XLEN-1:0]     vec_byp1[$];
    br_pipe_pkg::br_result_t vec_exp[$];
    expect_t                 exp_q[$];

    int          errors;
    int          edge_cnt;
    int          cycle_limit;
    int          last_mp_edge;  // capture edge of the last surviving mispredict
    int          vec_idx;
    logic        timed_out;

    br_exec_top dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_pkt      (in_pkt),
        .byp0        (byp0),
        .byp1        (byp1),
        .res_valid   (res_valid),
        .res         (res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .upd_valid   (upd_valid),
        .upd         (upd)
    );

    bind br_redirect br_exec_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .flush     (flush),
        .res_valid (res_valid),
        .redirect  (redirect),
        .upd_valid (upd_valid)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [`BR_XLEN-1:0] got,
                                   input logic [`BR_XLEN-1:0] want);
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    task automatic load_vectors();
        int                      fd;
        int                      n;
        string                   line;
        logic [31:0]             pc_v, cmt_v, isb_v, cond_v, sel1_v, sel2_v;
        logic [31:0]             imm_v, rs1_v, rs2_v, pt_v, ppc_v, b0_v, b1_v;
        logic [31:0]             tk_v, tg_v, df_v, af_v;
        br_pipe_pkg::br_issue_t  p;
        br_pipe_pkg::br_result_t e;
        fd = $fopen("sim/br_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/br_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 8 || line.substr(0, 0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            pc_v, cmt_v, isb_v, cond_v, sel1_v, sel2_v, imm_v, rs1_v,
                            rs2_v, pt_v, ppc_v, b0_v, b1_v, tk_v, tg_v, df_v, af_v);
                if (n != 17) begin
                    $display("malformed line in sim/br_tests.txt: %s", line);
                    errors++;
                end else begin
                    p.pc            = pc_v;
                    p.cmt           = cmt_v[0];
                    p.uop.is_branch = isb_v[0];
                    p.uop.cond      = br_uop_pkg::br_cond_e'(cond_v[3:0]);
                    p.uop.sel1      = br_uop_pkg::br_src_sel_e'(sel1_v[1:0]);
                    p.uop.sel2      = br_uop_pkg::br_src_sel_e'(sel2_v[1:0]);
                    p.imm           = imm_v;
                    p.rs1           = rs1_v;
                    p.rs2           = rs2_v;
                    p.pred_taken    = pt_v[0];
                    p.pred_pc       = ppc_v;
                    e.pc            = pc_v;
                    e.is_branch     = isb_v[0];
                    e.taken         = tk_v[0];
                    e.target        = tg_v;
                    e.dir_fail      = df_v[0];
                    e.addr_fail     = af_v[0];
                    vec_pkt.push_back(p);
                    vec_byp0.push_back(b0_v);
                    vec_byp1.push_back(b1_v);
                    vec_exp.push_back(e);
                end
            end
            $fclose(fd);
            if (vec_pkt.size() == 0) begin
                $display("no test vectors found in sim/br_tests.txt");
                errors++;
            end
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        if (res_valid) begin
            if (exp_q.size() == 0) begin
                $display("[ERROR] %0t: res_valid with no micro-op in flight", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (e.res_edge != edge_cnt) begin
                    $display("[ERROR] %0t: result for pc %h at cycle %0d, expected cycle %0d",
                             $time, e.r.pc, edge_cnt, e.res_edge);
                    errors++;
                end
                if (res.pc !== e.r.pc) report_mismatch("res.pc", res.pc, e.r.pc);
                if (res.is_branch !== e.r.is_branch)
                    report_mismatch("res.is_branch", 32'(res.is_branch), 32'(e.r.is_branch));
                if (res.taken !== e.r.taken)
                    report_mismatch("res.taken", 32'(res.taken), 32'(e.r.taken));
                if (res.target !== e.r.target)
                    report_mismatch("res.target", res.target, e.r.target);
                if (res.dir_fail !== e.r.dir_fail)
                    report_mismatch("res.dir_fail", 32'(res.dir_fail), 32'(e.r.dir_fail));
                if (res.addr_fail !== e.r.addr_fail)
                    report_mismatch("res.addr_fail", 32'(res.addr_fail), 32'(e.r.addr_fail));
                if (redirect !== (e.r.dir_fail | e.r.addr_fail))
                    report_mismatch("redirect", 32'(redirect),
                                    32'(e.r.dir_fail | e.r.addr_fail));
                if (redirect_pc !== e.r.target)
                    report_mismatch("redirect_pc", redirect_pc, e.r.target);
                if (upd_valid !== e.r.is_branch)
                    report_mismatch("upd_valid", 32'(upd_valid), 32'(e.r.is_branch));
                if (e.r.is_branch) begin
                    if (upd.pc !== e.r.pc) report_mismatch("upd.pc", upd.pc, e.r.pc);
                    if (upd.taken !== e.r.taken)
                        report_mismatch("upd.taken", 32'(upd.taken), 32'(e.r.taken));
                    if (upd.target !== e.r.target)
                        report_mismatch("upd.target", upd.target, e.r.target);
                end
            end
        end else begin
            if (redirect !== 1'b0) report_mismatch("redirect", 32'(redirect), 32'd0);
            if (upd_valid !== 1'b0) report_mismatch("upd_valid", 32'(upd_valid), 32'd0);
            if (exp_q.size() > 0 && exp_q[0].res_edge <= edge_cnt) begin
                e = exp_q.pop_front();
                $display("[ERROR] %0t: no result for pc %h", $time, e.r.pc);
                errors++;
            end
        end
    endtask

    task automatic drive_next();
        int      capture;
        logic    idle;
        expect_t ex;
        capture  = edge_cnt + 1;
        // no bubbles inside a kill window, so the two victims follow back to back
        idle     = (capture - last_mp_edge > 2) && ($urandom_range(3, 0) == 0);
        in_valid = 1'b0;
        if (vec_idx < vec_pkt.size() && !idle) begin
            in_valid = 1'b1;
            in_pkt   = vec_pkt[vec_idx];
            byp0     = vec_byp0[vec_idx];
            byp1     = vec_byp1[vec_idx];
            if (capture - last_mp_edge > 2) begin  // survives the flush
                ex.r        = vec_exp[vec_idx];
                ex.res_edge = capture + 2;
                exp_q.push_back(ex);
                if (ex.r.dir_fail || ex.r.addr_fail) begin
                    last_mp_edge = capture;
                end
            end
            vec_idx++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_pkt       = '0;
        byp0         = '0;
        byp1         = '0;
        errors       = 0;
        edge_cnt     = 0;
        vec_idx      = 0;
        last_mp_edge = -100;
        timed_out    = 1'b0;
        void'($urandom(32'h6951177e));
        load_vectors();
        cycle_limit = 2 * vec_pkt.size() + 50;
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;
        while ((vec_idx < vec_pkt.size() || exp_q.size() > 0) && !timed_out) begin
            @(posedge clk);
            edge_cnt++;
            #0.5;
            check_outputs();
            if (edge_cnt >= cycle_limit) begin
                timed_out = 1'b1;
            end else begin
                drive_next();
            end
        end
        in_valid = 1'b0;
        repeat (3) begin  // nothing may trail the last result
            @(posedge clk);
            edge_cnt++;
            #0.5;
            check_outputs();
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, results never arrived for %0d micro-ops",
                     edge_cnt, exp_q.size());
            errors++;
        end
        $display("vectors %0d, errors %0d", vec_pkt.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim/br_exec_asserts.sv */
`timescale 1ns/1ps

module br_exec_asserts (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic flush,
    input logic res_valid,
    input logic redirect,
    input logic upd_valid
);

    // a redirect always rides on a result
    redirect_has_result: assert property (
        @(posedge clk) disable iff (rst) redirect |-> res_valid
    ) else $error("redirect raised without res_valid");

    flush_kills_next: assert property (
        @(posedge clk) disable iff (rst) flush |=> !in_valid
    ) else $error("stage 3 still valid in the cycle after a flush");

    redirect_one_cycle: assert property (
        @(posedge clk) disable iff (rst) redirect |=> !redirect
    ) else $error("redirect held high for two cycles");

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> !(res_valid || redirect || upd_valid)
    ) else $error("output active in the cycle after reset");

endmodule

/* hw/br_exec_top.sv */
`timescale 1ns/1ps

`include "br_defines.svh"

module br_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  br_pipe_pkg::br_issue_t  in_pkt,
    input  logic [`BR_XLEN-1:0]     byp0,
    input  logic [`BR_XLEN-1:0]     byp1,
    output logic                    res_valid,
    output br_pipe_pkg::br_result_t res,
    output logic                    redirect,
    output logic [`BR_XLEN-1:0]     redirect_pc,
    output logic                    upd_valid,
    output br_pipe_pkg::br_update_t upd
);

    br_pipe_pkg::br_exec_t   s1_in;
    br_pipe_pkg::br_exec_t   s1_data;
    br_pipe_pkg::br_result_t s2_in;
    br_pipe_pkg::br_result_t s2_data;
    logic                    s1_valid;
    logic                    s2_valid;
    logic                    flush;

    br_operand_sel u_operand_sel (
        .in_pkt  (in_pkt),
        .byp0    (byp0),
        .byp1    (byp1),
        .out_pkt (s1_in)
    );

    // flush blocks the incoming uop
    br_stage_reg #(.payload_t(br_pipe_pkg::br_exec_t)) s1_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_data   (s1_in),
        .out_valid (s1_valid),
        .out_data  (s1_data)
    );

    br_resolve u_resolve (
        .pkt    (s1_data),
        .result (s2_in)
    );

    // flush drops whatever sat in s1
    br_stage_reg #(.payload_t(br_pipe_pkg::br_result_t)) s2_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (s1_valid),
        .in_data   (s2_in),
        .out_valid (s2_valid),
        .out_data  (s2_data)
    );

    br_redirect u_redirect (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (s2_valid),
        .in_res      (s2_data),
        .flush       (flush),
        .res_valid   (res_valid),
        .res         (res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .upd_valid   (upd_valid),
        .upd         (upd)
    );

endmodule

/* hw/br_redirect.sv */
`timescale 1ns/1ps

`include "br_defines.svh"

module br_redirect (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  br_pipe_pkg::br_result_t in_res,
    output logic                    flush,
    output logic                    res_valid,
    output br_pipe_pkg::br_result_t res,
    output logic                    redirect,
    output logic [`BR_XLEN-1:0]     redirect_pc,
    output logic                    upd_valid,
    output br_pipe_pkg::br_update_t upd
);

    logic mispredict;

    assign mispredict = in_res.dir_fail | in_res.addr_fail;

    // kills the two younger uops behind this one
    assign flush = in_valid & mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            redirect  <= 1'b0;
            upd_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
            redirect  <= flush;
            upd_valid <= in_valid & in_res.is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            res         <= in_res;
            redirect_pc <= in_res.target;  // step already folded in
            upd.pc      <= in_res.pc;
            upd.taken   <= in_res.taken;
            upd.target  <= in_res.target;
        end
    end

endmodule

/* hw/br_resolve.sv */
`timescale 1ns/1ps

`include "br_defines.svh"

module br_resolve (
    input  br_pipe_pkg::br_exec_t   pkt,
    output br_pipe_pkg::br_result_t result
);

    logic                src_eq;
    logic                src_ltu;
    logic                src_lt;
    logic                cond_hit;
    logic                taken;
    logic [`BR_XLEN-1:0] offs;
    logic [`BR_XLEN-1:0] seq_pc;
    logic [`BR_XLEN-1:0] br_pc;
    logic [`BR_XLEN-1:0] target;
    logic                pc_miss;

    assign src_eq  = (pkt.src1 == pkt.src2);
    assign src_ltu = (pkt.src1 < pkt.src2);
    assign src_lt  = ($signed(pkt.src1) < $signed(pkt.src2));

    always_comb begin
        case (pkt.uop.cond)
            br_uop_pkg::JIRL,
            br_uop_pkg::B,
            br_uop_pkg::BL:   cond_hit = 1'b1;  // unconditional
            br_uop_pkg::BEQ:  cond_hit = src_eq;
            br_uop_pkg::BNE:  cond_hit = ~src_eq;
            br_uop_pkg::BLT:  cond_hit = src_lt;
            br_uop_pkg::BGE:  cond_hit = ~src_lt;
            br_uop_pkg::BLTU: cond_hit = src_ltu;
            br_uop_pkg::BGEU: cond_hit = ~src_ltu;
            default:          cond_hit = 1'b0;
        endcase
    end

    assign taken = pkt.uop.is_branch & cond_hit;

    assign offs   = pkt.imm << `BR_IMM_SHIFT;
    assign seq_pc = pkt.cmt ? pkt.pc + `BR_XLEN'(`BR_STEP_CMT)
                            : pkt.pc + `BR_XLEN'(`BR_STEP_PAIR);

    // jirl is register indirect, the rest pc relative
    assign br_pc  = (pkt.uop.cond == br_uop_pkg::JIRL) ? pkt.src1 + offs
                                                        : pkt.pc + offs;
    assign target = taken ? br_pc : seq_pc;

    assign pc_miss = (pkt.pred_pc != target);

    always_comb begin
        result.pc        = pkt.pc;
        result.is_branch = pkt.uop.is_branch;
        result.taken     = taken;
        result.target    = target;
        if (taken != pkt.pred_taken) begin
            result.dir_fail  = 1'b1;
            result.addr_fail = 1'b1;
        end else if (taken && pc_miss) begin
            // right direction, wrong place
            result.dir_fail  = 1'b0;
            result.addr_fail = 1'b1;
        end else begin
            result.dir_fail  = 1'b0;
            result.addr_fail = 1'b0;
        end
    end

endmodule

/* hw/br_operand_sel.sv */
`timescale 1ns/1ps

`include "br_defines.svh"

module br_operand_sel (
    input  br_pipe_pkg::br_issue_t in_pkt,
    input  logic [`BR_XLEN-1:0]    byp0,
    input  logic [`BR_XLEN-1:0]    byp1,
    output br_pipe_pkg::br_exec_t  out_pkt
);

    function automatic logic [`BR_XLEN-1:0] pick_src(
        input br_uop_pkg::br_src_sel_e sel,
        input logic [`BR_XLEN-1:0]     rs,
        input logic [`BR_XLEN-1:0]     b0,
        input logic [`BR_XLEN-1:0]     b1
    );
        logic [`BR_XLEN-1:0] val;
        case (sel)
            br_uop_pkg::BYP0: val = b0;
            br_uop_pkg::BYP1: val = b1;
            default:          val = rs;  // reg file value
        endcase
        return val;
    endfunction

    always_comb begin
        out_pkt.pc         = in_pkt.pc;
        out_pkt.cmt        = in_pkt.cmt;
        out_pkt.uop        = in_pkt.uop;
        out_pkt.imm        = in_pkt.imm;
        out_pkt.src1       = pick_src(in_pkt.uop.sel1, in_pkt.rs1, byp0, byp1);
        out_pkt.src2       = pick_src(in_pkt.uop.sel2, in_pkt.rs2, byp0, byp1);
        out_pkt.pred_taken = in_pkt.pred_taken;
        out_pkt.pred_pc    = in_pkt.pred_pc;
    end

endmodule

/* hw/br_stage_reg.sv */
`timescale 1ns/1ps

module br_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // hold payload on bubbles
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

/* hw/br_pipe_pkg.sv */
`include "br_defines.svh"

package br_pipe_pkg;

    // as issued, before forwarding
    typedef struct packed {
        logic [`BR_XLEN-1:0]   pc;
        logic                  cmt;
        br_uop_pkg::br_uop_t   uop;
        logic [`BR_XLEN-1:0]   imm;
        logic [`BR_XLEN-1:0]   rs1;
        logic [`BR_XLEN-1:0]   rs2;
        logic                  pred_taken;
        logic [`BR_XLEN-1:0]   pred_pc;
    } br_issue_t;

    // operands resolved
    typedef struct packed {
        logic [`BR_XLEN-1:0]   pc;
        logic                  cmt;
        br_uop_pkg::br_uop_t   uop;
        logic [`BR_XLEN-1:0]   imm;
        logic [`BR_XLEN-1:0]   src1;
        logic [`BR_XLEN-1:0]   src2;
        logic                  pred_taken;
        logic [`BR_XLEN-1:0]   pred_pc;
    } br_exec_t;

    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;
        logic                is_branch;  // gates the predictor update
        logic                taken;
        logic [`BR_XLEN-1:0] target;     // next pc, taken or not
        logic                dir_fail;
        logic                addr_fail;
    } br_result_t;

    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;
        logic                taken;
        logic [`BR_XLEN-1:0] target;
    } br_update_t;

endpackage

/* hw/br_uop_pkg.sv */
`include "br_defines.svh"

package br_uop_pkg;

    // branch condition codes, anything else is not a branch
    typedef enum logic [`BR_COND_W-1:0] {
        JIRL = 4'd3,
        B    = 4'd4,
        BL   = 4'd5,
        BEQ  = 4'd6,
        BNE  = 4'd7,
        BLT  = 4'd8,
        BGE  = 4'd9,
        BLTU = 4'd10,
        BGEU = 4'd11
    } br_cond_e;

    // where an operand comes from
    typedef enum logic [`BR_SRC_SEL_W-1:0] {
        REG  = 2'd0,
        BYP0 = 2'd1,
        BYP1 = 2'd2
    } br_src_sel_e;

    typedef struct packed {
        logic        is_branch;
        br_cond_e    cond;
        br_src_sel_e sel1;
        br_src_sel_e sel2;
    } br_uop_t;

endpackage

/* hw/br_defines.svh */
`ifndef BR_DEFINES_SVH
`define BR_DEFINES_SVH

// datapath width, pc and operands alike
`define BR_XLEN 32

// uop field widths
`define BR_COND_W 4
`define BR_SRC_SEL_W 2

// sequential pc step, chosen by cmt
`define BR_STEP_CMT 4
`define BR_STEP_PAIR 8

// branch offsets are in words
`define BR_IMM_SHIFT 2

`endif
